// ==== rtl/d_cache_pkg.sv ====
package d_cache_pkg;

  // cache geometry
  localparam int addr_width   = 32;
  localparam int line_width   = 256;                 // one 32-byte line
  localparam int offset_width = 5;
  localparam int set_width    = 3;                   // 8 sets
  localparam int tag_width    = addr_width - set_width - offset_width;
  localparam int num_ways     = 4;
  localparam int way_width    = $clog2(num_ways);
  localparam int lru_width    = 3;                   // tree plru, one bit per node

  // one address word, seen raw or split into its fields
  typedef union packed {
    logic [addr_width-1:0] raw;
    struct packed {
      logic [tag_width-1:0]    tag;
      logic [set_width-1:0]    set;
      logic [offset_width-1:0] offset;
    } f;
  } d_cache_addr_u;

  // miss handling walks compare -> (write_back) -> fill -> compare
  typedef enum logic [1:0] {
    compare,
    write_back,
    fill
  } cache_state_e;

endpackage

// ==== rtl/cache_array.sv ====
`timescale 1ns/100ps

module cache_array
  import d_cache_pkg::*;
#(
  parameter int width = 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 load,
  input  logic [set_width-1:0] rindex,
  input  logic [set_width-1:0] windex,
  input  logic [width-1:0]     datain,
  output logic [width-1:0]     dataout
);

  logic [width-1:0] data [2**set_width];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 2**set_width; i++)
        data[i] <= '0;
    end
    else if (load)
    begin
      data[windex] <= datain;
    end
  end

  assign dataout = data[rindex]; // async read, new value visible after the edge

endmodule

// ==== rtl/d_cache_datapath.sv ====
`timescale 1ns/100ps

module d_cache_datapath
  import d_cache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  // cpu side
  input  logic [addr_width-1:0] address,
  input  logic [31:0]           wdata,
  input  logic [3:0]            mbe,
  input  logic                  mem_read,
  input  logic                  mem_write,
  output logic [31:0]           rdata,

  // memory side
  input  logic [line_width-1:0] pmem_rdata,
  output logic [addr_width-1:0] pmem_address,
  output logic [line_width-1:0] pmem_wdata,

  // from control
  input  logic                  load_stage,
  input  logic                  cpu_write_en,
  input  logic                  fill_en,
  input  logic [way_width-1:0]  victim_way,
  input  logic                  write_back_sel,
  input  logic                  lru_load,
  input  logic [lru_width-1:0]  lru_in,

  // to control
  output logic                  stage_valid,
  output logic                  stage_write,
  output logic                  hit,
  output logic [way_width-1:0]  hit_way,
  output logic [num_ways-1:0]   valid_bits,
  output logic [num_ways-1:0]   dirty_bits,
  output logic [lru_width-1:0]  lru_bits
);

  d_cache_addr_u stage_addr;
  logic [31:0]   stage_wdata;
  logic [3:0]    stage_mbe;
  d_cache_addr_u pmem_addr_u;

  logic [num_ways-1:0][tag_width-1:0]  tag_out;
  logic [num_ways-1:0][line_width-1:0] line_out;
  logic [num_ways-1:0]                 way_hit;
  logic [line_width-1:0]               hit_line;
  logic [line_width-1:0]               merged_line;
  logic [offset_width-3:0]             word_sel;

  // stage register, control part
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      stage_valid <= 1'b0;
      stage_write <= 1'b0;
    end
    else if (load_stage)
    begin
      stage_valid <= mem_read | mem_write; // idle input empties the stage
      stage_write <= mem_write;
    end
  end

  // stage register, payload
  always_ff @(posedge clk)
  begin
    if (load_stage)
    begin
      stage_addr.raw <= address;
      stage_wdata    <= wdata;
      stage_mbe      <= mbe;
    end
  end

  for (genvar w = 0; w < num_ways; w++)
  begin : g_way
    logic                  fill_this;
    logic                  write_this;
    logic [line_width-1:0] line_in;

    assign fill_this  = fill_en && (victim_way == way_width'(w));
    assign write_this = cpu_write_en && (hit_way == way_width'(w));
    assign line_in    = fill_this ? pmem_rdata : merged_line;

    cache_array #(.width(tag_width)) u_tag (
      .clk(clk), .rst(rst), .load(fill_this),
      .rindex(stage_addr.f.set), .windex(stage_addr.f.set),
      .datain(stage_addr.f.tag), .dataout(tag_out[w])
    );

    cache_array #(.width(1)) u_valid (
      .clk(clk), .rst(rst), .load(fill_this),
      .rindex(stage_addr.f.set), .windex(stage_addr.f.set),
      .datain(1'b1), .dataout(valid_bits[w])
    );

    // fill cleans the line, a cpu write dirties it
    cache_array #(.width(1)) u_dirty (
      .clk(clk), .rst(rst), .load(fill_this | write_this),
      .rindex(stage_addr.f.set), .windex(stage_addr.f.set),
      .datain(write_this), .dataout(dirty_bits[w])
    );

    cache_array #(.width(line_width)) u_data (
      .clk(clk), .rst(rst), .load(fill_this | write_this),
      .rindex(stage_addr.f.set), .windex(stage_addr.f.set),
      .datain(line_in), .dataout(line_out[w])
    );

    assign way_hit[w] = valid_bits[w] && (tag_out[w] == stage_addr.f.tag);
  end

  cache_array #(.width(lru_width)) u_lru (
    .clk(clk), .rst(rst), .load(lru_load),
    .rindex(stage_addr.f.set), .windex(stage_addr.f.set),
    .datain(lru_in), .dataout(lru_bits)
  );

  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < num_ways; w++)
      if (way_hit[w])
        hit_way = way_width'(w);
  end

  assign hit = |way_hit;

  assign word_sel = stage_addr.f.offset[offset_width-1:2];
  assign hit_line = line_out[hit_way];
  assign rdata    = hit_line[word_sel*32 +: 32];

  // byte merge into the hit line
  always_comb
  begin
    merged_line = hit_line;
    for (int b = 0; b < 4; b++)
      if (stage_mbe[b])
        merged_line[word_sel*32 + b*8 +: 8] = stage_wdata[b*8 +: 8];
  end

  always_comb
  begin
    pmem_addr_u.raw = stage_addr.raw;
    if (write_back_sel)
      pmem_addr_u.f.tag = tag_out[victim_way]; // victim sits in the same set
    pmem_addr_u.f.offset = '0;
  end

  assign pmem_address = pmem_addr_u.raw;
  assign pmem_wdata   = line_out[victim_way];

endmodule

// ==== rtl/d_cache_control.sv ====
`timescale 1ns/100ps

module d_cache_control
  import d_cache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pmem_resp,

  // from datapath
  input  logic                 stage_valid,
  input  logic                 stage_write,
  input  logic                 hit,
  input  logic [way_width-1:0] hit_way,
  input  logic [num_ways-1:0]  valid_bits,
  input  logic [num_ways-1:0]  dirty_bits,
  input  logic [lru_width-1:0] lru_bits,

  // strobes
  output logic                 mem_resp,
  output logic                 pmem_read,
  output logic                 pmem_write,

  // to datapath
  output logic                 load_stage,
  output logic                 cpu_write_en,
  output logic                 fill_en,
  output logic [way_width-1:0] victim_way,
  output logic                 write_back_sel,
  output logic                 lru_load,
  output logic [lru_width-1:0] lru_in
);

  cache_state_e state;
  cache_state_e next_state;
  logic         victim_dirty;

  // first invalid way, else follow the plru tree
  always_comb
  begin
    if (!valid_bits[0])
      victim_way = 2'd0;
    else if (!valid_bits[1])
      victim_way = 2'd1;
    else if (!valid_bits[2])
      victim_way = 2'd2;
    else if (!valid_bits[3])
      victim_way = 2'd3;
    else if (!lru_bits[2])
      victim_way = lru_bits[0] ? 2'd2 : 2'd3;
    else
      victim_way = lru_bits[1] ? 2'd0 : 2'd1;
  end

  assign victim_dirty = valid_bits[victim_way] && dirty_bits[victim_way];

  // point the tree away from the way just used
  always_comb
  begin
    case (hit_way)
      2'd0:    lru_in = {1'b0, 1'b0, lru_bits[0]};
      2'd1:    lru_in = {1'b0, 1'b1, lru_bits[0]};
      2'd2:    lru_in = {1'b1, lru_bits[1], 1'b0};
      default: lru_in = {1'b1, lru_bits[1], 1'b1};
    endcase
  end

  always_comb
  begin
    mem_resp       = 1'b0;
    pmem_read      = 1'b0;
    pmem_write     = 1'b0;
    load_stage     = 1'b0;
    cpu_write_en   = 1'b0;
    fill_en        = 1'b0;
    write_back_sel = 1'b0;
    lru_load       = 1'b0;
    case (state)
      compare:
      begin
        if (stage_valid && hit)
        begin
          mem_resp     = 1'b1;
          lru_load     = 1'b1;
          cpu_write_en = stage_write;
        end
        load_stage = !stage_valid || hit; // a miss stalls the stage
      end
      write_back:
      begin
        pmem_write     = 1'b1; // held until pmem_resp
        write_back_sel = 1'b1;
      end
      fill:
      begin
        pmem_read = 1'b1;
        fill_en   = pmem_resp;
      end
      default:
      begin
        load_stage = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    next_state = state;
    case (state)
      compare:
      begin
        if (stage_valid && !hit)
          next_state = victim_dirty ? write_back : fill;
      end
      write_back:
      begin
        if (pmem_resp)
          next_state = fill;
      end
      fill:
      begin
        if (pmem_resp)
          next_state = compare; // repeat the compare, which now hits
      end
      default:
      begin
        next_state = compare;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= compare;
    else
      state <= next_state;
  end

endmodule

// ==== rtl/d_cache.sv ====
`timescale 1ns/100ps

module d_cache
  import d_cache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  // cpu side
  input  logic                  mem_read,
  input  logic                  mem_write,
  input  logic [addr_width-1:0] address,
  input  logic [31:0]           wdata,
  input  logic [3:0]            mbe,
  output logic                  mem_resp,
  output logic [31:0]           rdata,

  // memory side
  output logic                  pmem_read,
  output logic                  pmem_write,
  output logic [addr_width-1:0] pmem_address,
  output logic [line_width-1:0] pmem_wdata,
  input  logic                  pmem_resp,
  input  logic [line_width-1:0] pmem_rdata
);

  logic                 stage_valid;
  logic                 stage_write;
  logic                 hit;
  logic [way_width-1:0] hit_way;
  logic [num_ways-1:0]  valid_bits;
  logic [num_ways-1:0]  dirty_bits;
  logic [lru_width-1:0] lru_bits;
  logic                 load_stage;
  logic                 cpu_write_en;
  logic                 fill_en;
  logic [way_width-1:0] victim_way;
  logic                 write_back_sel;
  logic                 lru_load;
  logic [lru_width-1:0] lru_in;

  d_cache_control u_control (
    .clk(clk), .rst(rst), .pmem_resp(pmem_resp),
    .stage_valid(stage_valid), .stage_write(stage_write),
    .hit(hit), .hit_way(hit_way),
    .valid_bits(valid_bits), .dirty_bits(dirty_bits), .lru_bits(lru_bits),
    .mem_resp(mem_resp), .pmem_read(pmem_read), .pmem_write(pmem_write),
    .load_stage(load_stage), .cpu_write_en(cpu_write_en), .fill_en(fill_en),
    .victim_way(victim_way), .write_back_sel(write_back_sel),
    .lru_load(lru_load), .lru_in(lru_in)
  );

  d_cache_datapath u_datapath (
    .clk(clk), .rst(rst),
    .address(address), .wdata(wdata), .mbe(mbe),
    .mem_read(mem_read), .mem_write(mem_write), .rdata(rdata),
    .pmem_rdata(pmem_rdata), .pmem_address(pmem_address), .pmem_wdata(pmem_wdata),
    .load_stage(load_stage), .cpu_write_en(cpu_write_en), .fill_en(fill_en),
    .victim_way(victim_way), .write_back_sel(write_back_sel),
    .lru_load(lru_load), .lru_in(lru_in),
    .stage_valid(stage_valid), .stage_write(stage_write),
    .hit(hit), .hit_way(hit_way),
    .valid_bits(valid_bits), .dirty_bits(dirty_bits), .lru_bits(lru_bits)
  );

endmodule

// ==== testbench/d_cache_assertions.sv ====
`timescale 1ns/100ps

module d_cache_assertions
  import d_cache_pkg::*;
(
  input logic         clk,
  input logic         rst,
  input logic         pmem_read,
  input logic         pmem_write,
  input logic         pmem_resp,
  input logic         mem_resp,
  input cache_state_e state
);

  a_one_strobe: assert property (@(posedge clk) disable iff (rst)
    !(pmem_read && pmem_write))
    else $error("pmem_read and pmem_write high together");

  a_read_hold: assert property (@(posedge clk) disable iff (rst)
    (pmem_read && !pmem_resp) |=> pmem_read)
    else $error("pmem_read dropped before pmem_resp");

  a_write_hold: assert property (@(posedge clk) disable iff (rst)
    (pmem_write && !pmem_resp) |=> pmem_write)
    else $error("pmem_write dropped before pmem_resp");

  // responses only come out of a compare
  a_resp_in_compare: assert property (@(posedge clk) disable iff (rst)
    mem_resp |-> state == compare)
    else $error("mem_resp outside compare");

endmodule

bind d_cache_control d_cache_assertions u_assertions (
  .clk(clk), .rst(rst), .pmem_read(pmem_read), .pmem_write(pmem_write),
  .pmem_resp(pmem_resp), .mem_resp(mem_resp), .state(state)
);

// ==== testbench/d_cache_tb.sv ====
`timescale 1ns/100ps

module d_cache_tb
  import d_cache_pkg::*;
();

  logic                  clk;
  logic                  rst;
  logic                  mem_read;
  logic                  mem_write;
  logic [addr_width-1:0] address;
  logic [31:0]           wdata;
  logic [3:0]            mbe;
  logic                  mem_resp;
  logic [31:0]           rdata;
  logic                  pmem_read;
  logic                  pmem_write;
  logic [addr_width-1:0] pmem_address;
  logic [line_width-1:0] pmem_wdata;
  logic                  pmem_resp;
  logic [line_width-1:0] pmem_rdata;

  // operations from the data file
  string       op_name[$];
  logic        op_write[$];
  logic [31:0] op_addr[$];
  logic [31:0] op_wdata[$];
  logic [3:0]  op_mbe[$];
  logic [31:0] op_rdata[$];
  int          op_fills[$];

  logic [line_width-1:0] mem_lines [logic [26:0]]; // lines written back
  integer seed = 24314;
  int     delay_left;
  logic   mem_busy;
  int     error_count;

  d_cache u_dut (
    .clk(clk), .rst(rst),
    .mem_read(mem_read), .mem_write(mem_write), .address(address),
    .wdata(wdata), .mbe(mbe), .mem_resp(mem_resp), .rdata(rdata),
    .pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_address(pmem_address),
    .pmem_wdata(pmem_wdata), .pmem_resp(pmem_resp), .pmem_rdata(pmem_rdata)
  );

  initial
    clk = 1'b0;

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      error_count++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic load_testdata();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       rw;
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] m;
    logic [31:0] r;
    int          f;
    fd = $fopen("testbench/d_cache_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the test data file");
      $display("TEST RESULT: FAIL");
      $fatal(1, "no test data");
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#")
      begin
        n = $sscanf(line, "%s %s %h %h %h %h %d", name, rw, a, w, m, r, f);
        if (n == 7)
        begin
          op_name.push_back(name);
          op_write.push_back(rw == "W");
          op_addr.push_back(a);
          op_wdata.push_back(w);
          op_mbe.push_back(m[3:0]);
          op_rdata.push_back(r);
          op_fills.push_back(f);
        end
      end
    end
    $fclose(fd);
  endtask

  // untouched memory holds word address ^ constant
  function automatic logic [line_width-1:0] line_at(input logic [26:0] idx);
    logic [line_width-1:0] ln;
    logic [31:0]           waddr;
    if (mem_lines.exists(idx))
      return mem_lines[idx];
    for (int i = 0; i < 8; i++)
    begin
      waddr = {2'b00, idx, 3'(i)};
      ln[i*32 +: 32] = waddr ^ 32'h1234_0000;
    end
    return ln;
  endfunction

  // memory model answering after 1 to 4 cycles
  always @(posedge clk)
  begin
    if (rst)
    begin
      pmem_resp <= 1'b0;
      mem_busy = 1'b0;
    end
    else if (pmem_resp)
      pmem_resp <= 1'b0; // strobe drops at this edge
    else if (pmem_read || pmem_write)
    begin
      if (!mem_busy)
      begin
        mem_busy = 1'b1;
        delay_left = int'($unsigned($random(seed)) % 4) + 1;
      end
      delay_left--;
      if (delay_left == 0)
      begin
        mem_busy = 1'b0;
        pmem_resp <= 1'b1;
        check_value("pmem_address offset", 32'd0, 32'(pmem_address[offset_width-1:0]));
        if (pmem_write)
          mem_lines[pmem_address[31:5]] = pmem_wdata;
        else
          pmem_rdata <= line_at(pmem_address[31:5]);
      end
    end
  end

  // cpu driver mirrors the stage to know when inputs are captured
  initial
  begin
    int cycle;
    int limit;
    int next_op;
    int done_ops;
    int present_idx;
    int stage_op;
    int capture_cycle;
    int fill_count;
    int fills_at_capture;
    logic presenting;
    logic stage_busy;
    rst        <= 1'b1;
    mem_read   <= 1'b0;
    mem_write  <= 1'b0;
    address    <= '0;
    wdata      <= '0;
    mbe        <= '0;
    pmem_resp  <= 1'b0;
    pmem_rdata <= '0;
    error_count = 0;
    cycle = 0;
    next_op = 0;
    done_ops = 0;
    present_idx = 0;
    stage_op = 0;
    capture_cycle = 0;
    fill_count = 0;
    fills_at_capture = 0;
    presenting = 1'b0;
    stage_busy = 1'b0;
    load_testdata();
    limit = op_name.size() * 20 + 5;
    repeat (5)
    begin
      @(posedge clk);
      check_value("reset_quiet", 32'd0, {29'd0, mem_resp, pmem_read, pmem_write});
    end
    rst <= 1'b0;
    while (done_ops < op_name.size())
    begin
      @(posedge clk);
      cycle++;
      if (cycle > limit)
      begin
        $display("timeout: the cache stopped answering after %0d cycles", cycle);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
      end
      if (cycle == 1)
        check_value("after_reset", 32'd0, {29'd0, mem_resp, pmem_read, pmem_write});
      if (pmem_read && pmem_resp)
        fill_count++;
      if (mem_resp)
      begin
        if (!stage_busy)
        begin
          $display("mem_resp came without any request in the stage");
          $display("TEST RESULT: FAIL");
          $fatal(1, "spurious mem_resp");
        end
        check_value({op_name[stage_op], " fills"}, 32'(op_fills[stage_op]),
                    32'(fill_count - fills_at_capture));
        if (!op_write[stage_op])
          check_value({op_name[stage_op], " rdata"}, op_rdata[stage_op], rdata);
        if (op_fills[stage_op] == 0)
          check_value({op_name[stage_op], " latency"}, 32'd1, 32'(cycle - capture_cycle));
        done_ops++;
      end
      if (!stage_busy || mem_resp)
      begin
        stage_busy = presenting;
        if (presenting)
        begin
          stage_op = present_idx;
          capture_cycle = cycle;
          fills_at_capture = fill_count;
        end
        if (next_op < op_name.size())
        begin
          mem_read    <= !op_write[next_op];
          mem_write   <= op_write[next_op];
          address     <= op_addr[next_op];
          wdata       <= op_wdata[next_op];
          mbe         <= op_mbe[next_op];
          present_idx = next_op;
          presenting  = 1'b1;
          next_op++;
        end
        else
        begin
          mem_read   <= 1'b0;
          mem_write  <= 1'b0;
          presenting = 1'b0;
        end
      end
    end
    if (error_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== testbench/d_cache_testdata.txt ====
# name rw(R/W) address wdata mbe expected_rdata expected_fills (hex, fills decimal)
# untouched memory words read as (byte address >> 2) ^ 12340000
# read miss, then the same line hits
rd_miss     R 00001024 00000000 0 12340409 1
rd_hit      R 00001024 00000000 0 12340409 0
# partial write hit, bytes 0 and 2
wr_part     W 00001028 aabbccdd 5 00000000 0
rd_merge    R 00001028 00000000 0 12bb04dd 0
# five tags in set 2, way 0 dirty
ev_w0       W 00002040 11111111 f 00000000 1
ev_r1       R 00003040 00000000 0 12340c10 1
ev_r2       R 00004040 00000000 0 12341010 1
ev_r3       R 00005040 00000000 0 12341410 1
# plru points at way 0, written back then refilled
ev_r4       R 00006040 00000000 0 12341810 1
# dirty data came back from memory, evicts way 2
ev_reread   R 00002040 00000000 0 11111111 1
ev_keep1    R 00003040 00000000 0 12340c10 0
ev_keep3    R 00005040 00000000 0 12341410 0
ev_gone2    R 00004044 00000000 0 12341011 1
# back to back hits
b2b_0       R 00001024 00000000 0 12340409 0
b2b_1       R 00001028 00000000 0 12bb04dd 0
b2b_2       R 0000103c 00000000 0 1234040f 0
b2b_3       R 00002044 00000000 0 12340811 0
b2b_4       R 00005048 00000000 0 12341412 0
b2b_5       R 00001020 00000000 0 12340408 0
# first touch of other sets
new_set5    R 000000a0 00000000 0 12340028 1
new_set5_h  R 000000bc 00000000 0 1234002f 0
new_set7    W 000000e4 cafef00d 3 00000000 1
rd_set7     R 000000e4 00000000 0 1234f00d 0

// ==== sim.f ====
rtl/d_cache_pkg.sv
rtl/cache_array.sv
rtl/d_cache_datapath.sv
rtl/d_cache_control.sv
rtl/d_cache.sv
testbench/d_cache_assertions.sv
testbench/d_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the d_cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module d_cache_tb -f sim.f -o d_cache_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/d_cache_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
echo "pass message not found"
exit 1
